// ==== logic/maze_pkg.sv ====
package maze_pkg;

    // Display geometry in pixels
    localparam int SCREEN_W  = 160;
    localparam int SCREEN_H  = 120;

    // Maze grid of square tiles
    localparam int TILE_SIZE = 5;
    localparam int GRID_COLS = 32;
    localparam int GRID_ROWS = 16;

    // Pixel coordinate widths
    localparam int X_W = 8;
    localparam int Y_W = 7;

    // Tile coordinate widths
    localparam int TILE_X_W = 5;
    localparam int TILE_Y_W = 4;

    // 4 bits each of red, green, blue
    typedef logic [11:0] color_t;

    localparam color_t BLACK = 12'h000;

    // Frame sequencer states
    typedef enum logic [2:0] {
        RS_IDLE,     // Sample positions
        RS_DRAW_BG,  // Full screen, first frame only
        RS_ERASE,    // Old positions back to background
        RS_DRAW,     // Objects at new positions
        RS_DONE      // Save positions, flag end of frame
    } render_state_t;

endpackage

// ==== logic/maze_bg_rom.sv ====
`timescale 1ns/10ps

module maze_bg_rom import maze_pkg::*; #(
    parameter color_t WALL_COLOR   = 12'h00F,
    parameter color_t PELLET_COLOR = 12'hFFF
) (
    input  logic           clock,
    input  logic           resetn,
    input  logic           enable,
    input  logic [X_W-1:0] bg_x,
    input  logic [Y_W-1:0] bg_y,
    output color_t         bg_color
);

    localparam int CENTER = TILE_SIZE / 2;  // Pellet sits mid tile

    logic [X_W-1:0] tile_x;
    logic [X_W-1:0] ofs_x;
    logic [Y_W-1:0] tile_y;  // Runs past the grid below row 15
    logic [Y_W-1:0] ofs_y;
    logic           is_wall;
    logic           is_pellet;
    color_t         pixel;

    assign tile_x = bg_x / X_W'(TILE_SIZE);
    assign ofs_x  = bg_x % X_W'(TILE_SIZE);
    assign tile_y = bg_y / Y_W'(TILE_SIZE);
    assign ofs_y  = bg_y % Y_W'(TILE_SIZE);

    // Border ring of tiles plus everything under the grid
    assign is_wall = (tile_x == '0) || (tile_x == X_W'(GRID_COLS - 1)) ||
                     (tile_y == '0) || (tile_y == Y_W'(GRID_ROWS - 1)) ||
                     (bg_y >= Y_W'(GRID_ROWS * TILE_SIZE));

    assign is_pellet = (ofs_x == X_W'(CENTER)) && (ofs_y == Y_W'(CENTER));

    always_comb begin
        if (is_wall)
            pixel = WALL_COLOR;
        else if (is_pellet)
            pixel = PELLET_COLOR;
        else
            pixel = BLACK;
    end

    // One cycle of read latency
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn)
            bg_color <= BLACK;
        else if (enable)
            bg_color <= pixel;
    end

endmodule

// ==== logic/player_sprite_rom.sv ====
`timescale 1ns/10ps

module player_sprite_rom import maze_pkg::*; #(
    parameter color_t PLAYER_COLOR = 12'hFF0
) (
    input  logic       clock,
    input  logic       resetn,
    input  logic       enable,
    input  logic [4:0] sprite_addr,
    output color_t     sprite_color
);

    localparam int DEPTH     = TILE_SIZE * TILE_SIZE;
    localparam int LAST      = TILE_SIZE - 1;
    localparam int MOUTH_ROW = TILE_SIZE / 2;

    color_t sprite_tab [DEPTH];

    // Round body, corners cut, mouth open to the right
    function automatic color_t pixel_at(int addr);
        int   dx;
        int   dy;
        logic corner;
        logic mouth;
        dx     = addr % TILE_SIZE;
        dy     = addr / TILE_SIZE;
        corner = (dx == 0 || dx == LAST) && (dy == 0 || dy == LAST);
        mouth  = (dy == MOUTH_ROW) && (dx >= LAST - 1);
        return (corner || mouth) ? BLACK : PLAYER_COLOR;
    endfunction

    for (genvar i = 0; i < DEPTH; i++) begin : g_tab
        assign sprite_tab[i] = pixel_at(i);
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn)
            sprite_color <= BLACK;
        else if (enable)
            sprite_color <= (sprite_addr < 5'(DEPTH)) ? sprite_tab[sprite_addr] : BLACK;
    end

endmodule

// ==== logic/sprite_renderer.sv ====
`timescale 1ns/10ps

module sprite_renderer import maze_pkg::*; #(
    parameter color_t GHOST_COLOR = 12'hF0F
) (
    input  logic                clock,
    input  logic                resetn,
    input  logic                enable,
    input  logic [TILE_X_W-1:0] pl_x,
    input  logic [TILE_Y_W-1:0] pl_y,
    input  logic [TILE_X_W-1:0] g1_x,
    input  logic [TILE_Y_W-1:0] g1_y,
    input  logic [TILE_X_W-1:0] g2_x,
    input  logic [TILE_Y_W-1:0] g2_y,
    input  logic [TILE_X_W-1:0] g3_x,
    input  logic [TILE_Y_W-1:0] g3_y,
    output logic [X_W-1:0]      bg_x,
    output logic [Y_W-1:0]      bg_y,
    input  color_t              bg_color,
    output logic [4:0]          sprite_addr,
    input  color_t              sprite_color,
    output logic [X_W-1:0]      vga_x,
    output logic [Y_W-1:0]      vga_y,
    output color_t              vga_color,
    output logic                plot,
    output logic                finished
);

    // Where the pixel colour comes from once the ROMs answer
    typedef enum logic [1:0] {
        SRC_BG,
        SRC_SPRITE,
        SRC_GHOST
    } color_src_t;

    localparam logic [2:0] LAST_OFS = 3'(TILE_SIZE - 1);
    localparam logic [1:0] LAST_OBJ = 2'd3;  // Player is 0, ghosts 1 to 3

    render_state_t       state;
    logic                first_frame;
    logic [X_W-1:0]      scan_x;
    logic [Y_W-1:0]      scan_y;
    logic [2:0]          dx;
    logic [2:0]          dy;
    logic [1:0]          obj_idx;

    logic [TILE_X_W-1:0] new_tx [4];  // Latched in idle
    logic [TILE_Y_W-1:0] new_ty [4];
    logic [TILE_X_W-1:0] old_tx [4];  // What the last frame drew
    logic [TILE_Y_W-1:0] old_ty [4];

    logic [TILE_X_W-1:0] cur_tx;
    logic [TILE_Y_W-1:0] cur_ty;
    logic [X_W-1:0]      obj_px;
    logic [Y_W-1:0]      obj_py;
    logic                scan_end;
    logic                block_end;
    logic                addr_valid;
    color_src_t          addr_src;

    logic [X_W-1:0]      s1_x;
    logic [Y_W-1:0]      s1_y;
    logic                s1_valid;
    color_src_t          s1_src;
    logic                s1_done;
    logic                plot_q;
    logic                finished_q;

    // Erase walks the saved positions, draw the fresh ones
    assign cur_tx = (state == RS_DRAW) ? new_tx[obj_idx] : old_tx[obj_idx];
    assign cur_ty = (state == RS_DRAW) ? new_ty[obj_idx] : old_ty[obj_idx];

    assign obj_px = X_W'(cur_tx) * X_W'(TILE_SIZE) + X_W'(dx);
    assign obj_py = Y_W'(cur_ty) * Y_W'(TILE_SIZE) + Y_W'(dy);

    assign bg_x        = (state == RS_DRAW_BG) ? scan_x : obj_px;
    assign bg_y        = (state == RS_DRAW_BG) ? scan_y : obj_py;
    assign sprite_addr = 5'(dy) * 5'(TILE_SIZE) + 5'(dx);

    assign scan_end   = (scan_x == X_W'(SCREEN_W - 1)) && (scan_y == Y_W'(SCREEN_H - 1));
    assign block_end  = (dx == LAST_OFS) && (dy == LAST_OFS);
    assign addr_valid = (state == RS_DRAW_BG) || (state == RS_ERASE) || (state == RS_DRAW);

    always_comb begin
        if (state == RS_DRAW)
            addr_src = (obj_idx == 2'd0) ? SRC_SPRITE : SRC_GHOST;
        else
            addr_src = SRC_BG;  // Background pass and erase
    end

    // Frame sequencer
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            state       <= RS_IDLE;
            first_frame <= 1'b1;
            scan_x      <= '0;
            scan_y      <= '0;
            dx          <= '0;
            dy          <= '0;
            obj_idx     <= '0;
            for (int i = 0; i < 4; i++) begin
                new_tx[i] <= '0;
                new_ty[i] <= '0;
                old_tx[i] <= '0;
                old_ty[i] <= '0;
            end
        end else if (enable) begin
            case (state)
                RS_IDLE: begin
                    new_tx[0] <= pl_x;
                    new_ty[0] <= pl_y;
                    new_tx[1] <= g1_x;
                    new_ty[1] <= g1_y;
                    new_tx[2] <= g2_x;
                    new_ty[2] <= g2_y;
                    new_tx[3] <= g3_x;
                    new_ty[3] <= g3_y;
                    dx      <= '0;
                    dy      <= '0;
                    obj_idx <= '0;
                    state   <= first_frame ? RS_DRAW_BG : RS_ERASE;
                end
                RS_DRAW_BG: begin
                    if (scan_x == X_W'(SCREEN_W - 1)) begin
                        scan_x <= '0;
                        scan_y <= scan_end ? '0 : scan_y + 1'b1;
                    end else begin
                        scan_x <= scan_x + 1'b1;
                    end
                    if (scan_end) begin
                        first_frame <= 1'b0;
                        state       <= RS_ERASE;
                    end
                end
                RS_ERASE, RS_DRAW: begin
                    // 5x5 raster per object, x fastest
                    if (dx == LAST_OFS) begin
                        dx <= '0;
                        if (dy == LAST_OFS) begin
                            dy      <= '0;
                            obj_idx <= obj_idx + 1'b1;  // Wraps to player after ghost 3
                        end else begin
                            dy <= dy + 1'b1;
                        end
                    end else begin
                        dx <= dx + 1'b1;
                    end
                    if (block_end && obj_idx == LAST_OBJ)
                        state <= (state == RS_ERASE) ? RS_DRAW : RS_DONE;
                end
                RS_DONE: begin
                    // Next frame erases what was just drawn
                    for (int i = 0; i < 4; i++) begin
                        old_tx[i] <= new_tx[i];
                        old_ty[i] <= new_ty[i];
                    end
                    state <= RS_IDLE;
                end
                default: state <= RS_IDLE;
            endcase
        end
    end

    // Stage 1 waits out the ROM latency, stage 2 picks the colour
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            s1_x       <= '0;
            s1_y       <= '0;
            s1_valid   <= 1'b0;
            s1_src     <= SRC_BG;
            s1_done    <= 1'b0;
            vga_x      <= '0;
            vga_y      <= '0;
            vga_color  <= BLACK;
            plot_q     <= 1'b0;
            finished_q <= 1'b0;
        end else if (enable) begin
            s1_x     <= bg_x;
            s1_y     <= bg_y;
            s1_valid <= addr_valid;
            s1_src   <= addr_src;
            s1_done  <= (state == RS_DONE);  // Trails the last pixel of the frame

            vga_x      <= s1_x;
            vga_y      <= s1_y;
            plot_q     <= s1_valid;
            finished_q <= s1_done;
            case (s1_src)
                SRC_SPRITE: vga_color <= sprite_color;
                SRC_GHOST:  vga_color <= GHOST_COLOR;
                default:    vga_color <= bg_color;
            endcase
        end
    end

    // Registers hold while stalled, so the strobes must not repeat
    assign plot     = plot_q & enable;
    assign finished = finished_q & enable;

endmodule

// ==== logic/maze_render_top.sv ====
`timescale 1ns/10ps

module maze_render_top import maze_pkg::*; #(
    parameter color_t WALL_COLOR   = 12'h00F,
    parameter color_t PELLET_COLOR = 12'hFFF,
    parameter color_t GHOST_COLOR  = 12'hF0F,
    parameter color_t PLAYER_COLOR = 12'hFF0
) (
    input  logic                clock,
    input  logic                resetn,
    input  logic                enable,
    input  logic [TILE_X_W-1:0] pl_x,
    input  logic [TILE_Y_W-1:0] pl_y,
    input  logic [TILE_X_W-1:0] g1_x,
    input  logic [TILE_Y_W-1:0] g1_y,
    input  logic [TILE_X_W-1:0] g2_x,
    input  logic [TILE_Y_W-1:0] g2_y,
    input  logic [TILE_X_W-1:0] g3_x,
    input  logic [TILE_Y_W-1:0] g3_y,
    output logic [X_W-1:0]      vga_x,
    output logic [Y_W-1:0]      vga_y,
    output color_t              vga_color,
    output logic                plot,
    output logic                finished
);

    logic [X_W-1:0] bg_x;
    logic [Y_W-1:0] bg_y;
    color_t         bg_color;
    logic [4:0]     sprite_addr;
    color_t         sprite_color;

    sprite_renderer #(
        .GHOST_COLOR (GHOST_COLOR)
    ) u_renderer (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .pl_x         (pl_x),
        .pl_y         (pl_y),
        .g1_x         (g1_x),
        .g1_y         (g1_y),
        .g2_x         (g2_x),
        .g2_y         (g2_y),
        .g3_x         (g3_x),
        .g3_y         (g3_y),
        .bg_x         (bg_x),
        .bg_y         (bg_y),
        .bg_color     (bg_color),
        .sprite_addr  (sprite_addr),
        .sprite_color (sprite_color),
        .vga_x        (vga_x),
        .vga_y        (vga_y),
        .vga_color    (vga_color),
        .plot         (plot),
        .finished     (finished)
    );

    // Maze walls and pellets
    maze_bg_rom #(
        .WALL_COLOR   (WALL_COLOR),
        .PELLET_COLOR (PELLET_COLOR)
    ) u_bg_rom (
        .clock    (clock),
        .resetn   (resetn),
        .enable   (enable),
        .bg_x     (bg_x),
        .bg_y     (bg_y),
        .bg_color (bg_color)
    );

    player_sprite_rom #(
        .PLAYER_COLOR (PLAYER_COLOR)
    ) u_sprite_rom (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .sprite_addr  (sprite_addr),
        .sprite_color (sprite_color)
    );

endmodule

// ==== tests/maze_render_chk.sv ====
`timescale 1ns/10ps

module maze_render_chk import maze_pkg::*; (
    input logic           clock,
    input logic           resetn,
    input logic           enable,
    input render_state_t  state,
    input logic [X_W-1:0] vga_x,
    input logic [Y_W-1:0] vga_y,
    input logic           plot,
    input logic           finished
);

    int unsigned fail_count = 0;  // Failed assertions so far

    quiet_in_reset: assert property (@(posedge clock) !resetn |-> (!plot && !finished))
        else begin
            $error("plot or finished high during reset");
            fail_count++;
        end

    // First cycle out of reset starts in idle
    clean_release: assert property (@(posedge clock)
        $rose(resetn) |-> (!plot && !finished && state == RS_IDLE))
        else begin
            $error("renderer not idle on reset release");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clock) $rose(resetn) |=> (!plot && !finished))
        else begin
            $error("strobe in the cycle after reset");
            fail_count++;
        end

    finished_single: assert property (@(posedge clock) disable iff (!resetn)
        finished |=> !finished)
        else begin
            $error("finished longer than one cycle");
            fail_count++;
        end

    on_screen: assert property (@(posedge clock) disable iff (!resetn)
        plot |-> (int'(vga_x) < SCREEN_W && int'(vga_y) < SCREEN_H))
        else begin
            $error("plotted coordinate off screen");
            fail_count++;
        end

    no_plot_stalled: assert property (@(posedge clock) !enable |-> !plot)
        else begin
            $error("plot while enable low");
            fail_count++;
        end

endmodule

bind sprite_renderer maze_render_chk u_chk (
    .clock    (clock),
    .resetn   (resetn),
    .enable   (enable),
    .state    (state),
    .vga_x    (vga_x),
    .vga_y    (vga_y),
    .plot     (plot),
    .finished (finished)
);

// ==== tests/maze_render_tb.sv ====
`timescale 1ns/10ps

module maze_render_tb import maze_pkg::*; ();

    localparam int FRAMES       = 3;
    localparam int FRAME_CYCLES = 210;  // Idle, erase, draw, done and pipeline slack
    localparam int RESET_CYCLES = 10;
    // Background pass once, every frame, plus room for the stalls in frame 2
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + SCREEN_W * SCREEN_H +
                                     FRAMES * FRAME_CYCLES + 4 * FRAME_CYCLES;

    logic                clock;
    logic                resetn;
    logic                enable;
    logic [TILE_X_W-1:0] obj_tx [4];  // Player, then ghosts 1 to 3
    logic [TILE_Y_W-1:0] obj_ty [4];
    logic [X_W-1:0]      vga_x;
    logic [Y_W-1:0]      vga_y;
    color_t              vga_color;
    logic                plot;
    logic                finished;

    int seed;
    int frame;
    int plot_count;
    int pos_x [FRAMES+1][4];  // Index 0 holds the reset positions
    int pos_y [FRAMES+1][4];
    int exp_x [$];
    int exp_y [$];
    int exp_c [$];

    maze_render_top DUT (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (enable),
        .pl_x      (obj_tx[0]),
        .pl_y      (obj_ty[0]),
        .g1_x      (obj_tx[1]),
        .g1_y      (obj_ty[1]),
        .g2_x      (obj_tx[2]),
        .g2_y      (obj_ty[2]),
        .g3_x      (obj_tx[3]),
        .g3_y      (obj_ty[3]),
        .vga_x     (vga_x),
        .vga_y     (vga_y),
        .vga_color (vga_color),
        .plot      (plot),
        .finished  (finished)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(string name, int expected, int actual);
        assert (expected == actual) else begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            report_failure();
        end
    endtask

    function automatic int bg_expect(int x, int y);
        int tx;
        int ty;
        tx = x / TILE_SIZE;
        ty = y / TILE_SIZE;
        if (tx == 0 || tx == 31 || ty == 0 || ty == 15 || y >= 80)
            return int'(DUT.WALL_COLOR);
        if (x % TILE_SIZE == 2 && y % TILE_SIZE == 2)
            return int'(DUT.PELLET_COLOR);  // Tile centre
        return 0;
    endfunction

    function automatic int sprite_expect(int dx, int dy);
        if ((dx == 0 || dx == 4) && (dy == 0 || dy == 4))
            return 0;
        if (dy == 2 && dx >= 3)
            return 0;  // Mouth
        return int'(DUT.PLAYER_COLOR);
    endfunction

    task automatic push_pixel(int x, int y, int c);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_c.push_back(c);
    endtask

    // Erase at the previous positions, then draw at the new ones
    task automatic expect_frame(int f);
        int px;
        int py;
        if (f == 1) begin
            for (int y = 0; y < SCREEN_H; y++)
                for (int x = 0; x < SCREEN_W; x++)
                    push_pixel(x, y, bg_expect(x, y));
        end
        for (int ph = 0; ph < 2; ph++)
            for (int o = 0; o < 4; o++)
                for (int dy = 0; dy < TILE_SIZE; dy++)
                    for (int dx = 0; dx < TILE_SIZE; dx++) begin
                        px = pos_x[f - 1 + ph][o] * TILE_SIZE + dx;
                        py = pos_y[f - 1 + ph][o] * TILE_SIZE + dy;
                        if (ph == 0)
                            push_pixel(px, py, bg_expect(px, py));
                        else if (o == 0)
                            push_pixel(px, py, sprite_expect(dx, dy));
                        else
                            push_pixel(px, py, int'(DUT.GHOST_COLOR));
                    end
    endtask

    task automatic drive_positions(int f);
        for (int o = 0; o < 4; o++) begin
            obj_tx[o] = TILE_X_W'(pos_x[f][o]);
            obj_ty[o] = TILE_Y_W'(pos_y[f][o]);
        end
    endtask

    initial begin
        seed       = 32'h50eb714e;
        frame      = 1;
        plot_count = 0;
        for (int o = 0; o < 4; o++) begin
            pos_x[0][o] = 0;
            pos_y[0][o] = 0;
        end
        for (int f = 1; f <= FRAMES; f++)
            for (int o = 0; o < 4; o++) begin
                pos_x[f][o] = 1 + int'($unsigned($random(seed)) % 30);  // Interior columns
                pos_y[f][o] = 1 + int'($unsigned($random(seed)) % 14);
            end
        resetn = 1'b0;
        enable = 1'b0;
        drive_positions(1);
        expect_frame(1);
        repeat (RESET_CYCLES) @(negedge clock);
        resetn = 1'b1;
        enable = 1'b1;
        wait (frame > FRAMES);
        repeat (5) @(posedge clock);
        $display("Simulation completed successfully");
        $finish;
    end

    // Stalls only in frame 2, stop the DUT once all frames are in
    always @(negedge clock) begin
        if (resetn) begin
            if (frame > FRAMES)
                enable = 1'b0;
            else if (frame == 2)
                enable = ($unsigned($random(seed)) % 4) != 0;
            else
                enable = 1'b1;
            if (plot_count > 0 && frame < FRAMES)
                drive_positions(frame + 1);  // Idle of this frame is past
        end
    end

    // Protocol checker bound inside the renderer
    always @(negedge clock) begin
        if (DUT.u_renderer.u_chk.fail_count != 0) begin
            $display("A protocol assertion on the renderer failed");
            report_failure();
        end
    end

    // Scoreboard
    always @(posedge clock) begin
        if (resetn && plot) begin
            assert (exp_c.size() > 0) else begin
                $display("Plot at %0t when no pixel was expected", $time);
                report_failure();
            end
            check_value("vga_x", exp_x.pop_front(), int'(vga_x));
            check_value("vga_y", exp_y.pop_front(), int'(vga_y));
            check_value("vga_color", exp_c.pop_front(), int'(vga_color));
            plot_count++;
        end
        if (resetn && finished) begin
            assert (exp_c.size() == 0) else begin
                $display("finished arrived with %0d pixels still missing", exp_c.size());
                report_failure();
            end
            frame++;
            plot_count = 0;
            if (frame <= FRAMES)
                expect_frame(frame);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout, finished never arrived for frame %0d", frame);
        report_failure();
    end

endmodule

// ==== maze_render.f ====
logic/maze_pkg.sv
logic/maze_bg_rom.sv
logic/player_sprite_rom.sv
logic/sprite_renderer.sv
logic/maze_render_top.sv
tests/maze_render_chk.sv
tests/maze_render_tb.sv

// ==== Makefile ====
# Verilator build and run of the maze renderer testbench

VERILATOR ?= verilator
TOP       ?= maze_render_tb
FILELIST  ?= maze_render.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
